//--- all.f
+incdir+hdl
hdl/buffer_pkg.sv
hdl/switch_pkg.sv
hdl/free_page_list.sv
hdl/page_bank.sv
hdl/port_ingress.sv
hdl/desc_queue.sv
hdl/port_egress.sv
hdl/switch_top.sv
tests/tb_clock_gen.sv
tests/tb_switch.sv

//--- Makefile
# Verilator flow for the packet switch testbench
VERILATOR ?= verilator
TOP       ?= tb_switch
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_switch.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module tb_switch;
    import switch_pkg::*;

    localparam int NP        = `SW_NUM_PORTS;
    localparam int MAX_WORDS = `SW_MAX_PAGES * `SW_PAGE_WORDS;
    localparam int EXP_DEPTH = 1024;
    localparam int LEN_DEPTH = 64;
    // about 640 halfwords at two cycles each, plus filling the bank in test 5
    localparam int EST_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES;

    logic          clk;
    logic          rst_n;
    logic [NP-1:0] wr_sop;
    logic [NP-1:0] wr_eop;
    logic [NP-1:0] wr_vld;
    half_t         wr_data [NP];
    logic [NP-1:0] full;
    logic [NP-1:0] ready;
    logic [NP-1:0] rd_sop;
    logic [NP-1:0] rd_eop;
    logic [NP-1:0] rd_vld;
    half_t         rd_data [NP];

    // expected halfwords and packet lengths per src * NP + dst
    half_t exp_word [NP*NP][EXP_DEPTH];
    int    exp_wr [NP*NP];
    int    exp_rd [NP*NP];
    int    len_q [NP*NP][LEN_DEPTH];
    int    len_wr [NP*NP];
    int    len_rd [NP*NP];

    // packet currently arriving on each output
    logic  busy [NP];
    int    cur_key [NP];
    int    cur_len [NP];
    int    cur_pos [NP];

    int     errors;
    int     mon_errors;
    int     pkts_in;
    int     pkts_out;
    int     cycles;
    integer seed;

    tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(8)) i_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    switch_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int k = 0; k < NP*NP; k++) begin
            if (exp_rd[k] != exp_wr[k] || len_rd[k] != len_wr[k]) begin
                empty = 1'b0;
            end
        end
        for (int d = 0; d < NP; d++) begin
            if (busy[d]) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // one transferred halfword on output d against the model
    task automatic check_output_word(input int d);
        int    src;
        int    key;
        logic  exp_eop;
        half_t exp_val;
        if (!busy[d]) begin
            assert (rd_sop[d] === 1'b1) else begin
                mon_errors++;
                $display("mismatch rd_sop[%0d]: expected 0x1 got 0x%h", d, rd_sop[d]);
            end
            // source port rides in bit 1 of the header
            src = int'(rd_data[d][1]);
            key = src * NP + d;
            assert (len_rd[key] != len_wr[key]) else begin
                mon_errors++;
                $display("output %0d began a packet from input %0d that was never sent", d, src);
            end
            if (len_rd[key] != len_wr[key]) begin
                busy[d]    = 1'b1;
                cur_key[d] = key;
                cur_len[d] = len_q[key][len_rd[key] % LEN_DEPTH];
                cur_pos[d] = 0;
                len_rd[key]++;
            end
        end else begin
            assert (rd_sop[d] === 1'b0) else begin
                mon_errors++;
                $display("mismatch rd_sop[%0d]: expected 0x0 got 0x%h", d, rd_sop[d]);
            end
        end
        if (busy[d]) begin
            key     = cur_key[d];
            exp_val = exp_word[key][exp_rd[key] % EXP_DEPTH];
            exp_eop = cur_pos[d] == cur_len[d] - 1;
            exp_rd[key]++;
            assert (rd_data[d] === exp_val) else begin
                mon_errors++;
                $display("mismatch rd_data[%0d]: expected 0x%h got 0x%h", d, exp_val, rd_data[d]);
            end
            assert (rd_eop[d] === exp_eop) else begin
                mon_errors++;
                $display("mismatch rd_eop[%0d]: expected 0x%h got 0x%h", d, exp_eop, rd_eop[d]);
            end
            cur_pos[d]++;
            if (cur_pos[d] == cur_len[d]) begin
                busy[d] = 1'b0;
                pkts_out++;
            end
        end
    endtask

    // a halfword moves on each cycle with rd_vld and ready both high
    always @(posedge clk) begin
        if (!rst_n) begin
            mon_errors = 0;
            pkts_out   = 0;
            for (int k = 0; k < NP*NP; k++) begin
                exp_rd[k] = 0;
                len_rd[k] = 0;
            end
            for (int d = 0; d < NP; d++) begin
                busy[d] = 1'b0;
            end
        end else begin
            for (int d = 0; d < NP; d++) begin
                if (rd_vld[d] && ready[d]) begin
                    check_output_word(d);
                end
            end
        end
    end

    // drives both inputs in lockstep and leaves an input idle at zero length
    task automatic send_pair(input int len0, input int dst0, input int len1, input int dst1);
        int          lens [NP];
        int          dsts [NP];
        int          key;
        int          n;
        logic [31:0] r;
        half_t       pkt [NP][MAX_WORDS];
        lens[0] = len0;
        lens[1] = len1;
        dsts[0] = dst0;
        dsts[1] = dst1;
        n = (len0 > len1) ? len0 : len1;
        for (int p = 0; p < NP; p++) begin
            if (lens[p] > 0) begin
                assert (full[p] === 1'b0) else begin
                    errors++;
                    $display("input %0d had to start a packet while full was high", p);
                end
                for (int i = 0; i < lens[p]; i++) begin
                    r = $random(seed);
                    pkt[p][i] = r[15:0];
                end
                // destination in bit 0, source in bit 1
                pkt[p][0] = (pkt[p][0] & 16'hfffc) | half_t'(p * NP + dsts[p]);
                key = p * NP + dsts[p];
                len_q[key][len_wr[key] % LEN_DEPTH] = lens[p];
                len_wr[key]++;
                for (int i = 0; i < lens[p]; i++) begin
                    exp_word[key][exp_wr[key] % EXP_DEPTH] = pkt[p][i];
                    exp_wr[key]++;
                end
                pkts_in++;
            end
        end
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            for (int p = 0; p < NP; p++) begin
                wr_vld[p]  = i < lens[p];
                wr_sop[p]  = i == 0 && lens[p] > 0;
                wr_eop[p]  = i == lens[p] - 1;
                wr_data[p] = (i < lens[p]) ? pkt[p][i] : '0;
            end
        end
        @(negedge clk);
        wr_vld = '0;
        wr_sop = '0;
        wr_eop = '0;
    endtask

    task automatic drain_outputs();
        @(negedge clk);
        while (!model_empty()) begin
            @(negedge clk);
        end
    endtask

    task automatic check_idle_after_reset();
        assert (full === '0) else begin
            errors++;
            $display("mismatch full: expected 0x0 got 0x%h", full);
        end
        assert (rd_vld === '0) else begin
            errors++;
            $display("mismatch rd_vld: expected 0x0 got 0x%h", rd_vld);
        end
        assert (rd_sop === '0) else begin
            errors++;
            $display("mismatch rd_sop: expected 0x0 got 0x%h", rd_sop);
        end
        assert (rd_eop === '0) else begin
            errors++;
            $display("mismatch rd_eop: expected 0x0 got 0x%h", rd_eop);
        end
    endtask

    task automatic short_packet_test();
        send_pair(5, 1, 0, 0);
        drain_outputs();
    endtask

    // 37 halfwords cover five pages
    task automatic page_linking_test();
        send_pair(0, 0, 37, 0);
        drain_outputs();
    endtask

    task automatic crossing_traffic_test();
        send_pair(20, 1, 23, 0);
        drain_outputs();
    endtask

    // both inputs merge onto output 0
    task automatic merge_test();
        send_pair(12, 0, 7, 0);
        send_pair(9, 0, 15, 0);
        drain_outputs();
    endtask

    task automatic backpressure_test();
        int    sent;
        half_t exp_head;
        sent = 0;
        ready[1] = 1'b0;
        while (!full[0] && sent < 4) begin
            send_pair(MAX_WORDS, 1, 0, 0);
            sent++;
        end
        assert (full[0] === 1'b1) else begin
            errors++;
            $display("full[0] stayed low after %0d packets of %0d halfwords", sent, MAX_WORDS);
        end
        // header of the first stalled packet is still held on output 1
        exp_head = exp_word[1][exp_rd[1] % EXP_DEPTH];
        assert (rd_vld[1] === 1'b1) else begin
            errors++;
            $display("mismatch rd_vld[1]: expected 0x1 got 0x%h", rd_vld[1]);
        end
        assert (rd_sop[1] === 1'b1) else begin
            errors++;
            $display("mismatch rd_sop[1]: expected 0x1 got 0x%h", rd_sop[1]);
        end
        assert (rd_data[1] === exp_head) else begin
            errors++;
            $display("mismatch rd_data[1]: expected 0x%h got 0x%h", exp_head, rd_data[1]);
        end
        @(negedge clk);
        ready[1] = 1'b1;
        drain_outputs();
    endtask

    // pages from test 5 must be back on the free list
    task automatic page_return_test();
        assert (full[0] === 1'b0) else begin
            errors++;
            $display("mismatch full[0]: expected 0x0 got 0x%h", full[0]);
        end
        for (int n = 0; n < 4; n++) begin
            send_pair(MAX_WORDS, 1, 0, 0);
        end
        drain_outputs();
    endtask

    task automatic print_counts();
        $display("errors: %0d, packets sent: %0d, packets delivered: %0d",
                 errors + mon_errors, pkts_in, pkts_out);
    endtask

    initial begin
        seed    = 92753;
        errors  = 0;
        pkts_in = 0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        ready   = '1;
        for (int p = 0; p < NP; p++) begin
            wr_data[p] = '0;
        end
        for (int k = 0; k < NP*NP; k++) begin
            exp_wr[k] = 0;
            len_wr[k] = 0;
        end
        @(posedge rst_n);
        @(negedge clk);
        check_idle_after_reset();
        short_packet_test();
        page_linking_test();
        crossing_traffic_test();
        merge_test();
        backpressure_test();
        page_return_test();
        print_counts();
        if (errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // released on a falling edge like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/switch_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module switch_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SW_NUM_PORTS-1:0] wr_sop,
    input  logic [`SW_NUM_PORTS-1:0] wr_eop,
    input  logic [`SW_NUM_PORTS-1:0] wr_vld,
    input  switch_pkg::half_t        wr_data [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] full,
    input  logic [`SW_NUM_PORTS-1:0] ready,
    output logic [`SW_NUM_PORTS-1:0] rd_sop,
    output logic [`SW_NUM_PORTS-1:0] rd_eop,
    output logic [`SW_NUM_PORTS-1:0] rd_vld,
    output switch_pkg::half_t        rd_data [`SW_NUM_PORTS]
);
    import buffer_pkg::*;
    import switch_pkg::*;

    port_id_t phase;

    // ingress to own bank
    logic [`SW_NUM_PORTS-1:0] ig_wr_en;
    logic [`SW_NUM_PORTS-1:0] ig_jt_wr_en;
    logic [`SW_NUM_PORTS-1:0] ig_page_pop;
    page_idx_t                ig_wr_page [`SW_NUM_PORTS];
    word_off_t                ig_wr_off [`SW_NUM_PORTS];
    half_t                    ig_wr_data [`SW_NUM_PORTS];
    page_idx_t                ig_jt_wr_page [`SW_NUM_PORTS];
    page_idx_t                ig_jt_next [`SW_NUM_PORTS];
    page_idx_t                bk_free_head [`SW_NUM_PORTS];
    free_cnt_t                bk_free_count [`SW_NUM_PORTS];

    // shared read and free side of the banks
    logic [`SW_NUM_PORTS-1:0] bk_rd_en;
    logic [`SW_NUM_PORTS-1:0] bk_free_push;
    page_idx_t                bk_rd_page [`SW_NUM_PORTS];
    word_off_t                bk_rd_off [`SW_NUM_PORTS];
    half_t                    bk_rd_data [`SW_NUM_PORTS];
    page_idx_t                bk_rd_next [`SW_NUM_PORTS];
    page_idx_t                bk_free_page [`SW_NUM_PORTS];

    // descriptors
    logic [`SW_NUM_PORTS-1:0] desc_valid;
    logic [`SW_NUM_PORTS-1:0] desc_accept;
    pkt_desc_t                desc [`SW_NUM_PORTS];
    port_id_t                 desc_dest [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0] q_valid;
    logic [`SW_NUM_PORTS-1:0] q_pop;
    pkt_desc_t                q_desc [`SW_NUM_PORTS];

    // egress requests
    logic [`SW_NUM_PORTS-1:0] eg_rd_en;
    logic [`SW_NUM_PORTS-1:0] eg_free_push;
    bank_id_t                 eg_rd_bank [`SW_NUM_PORTS];
    page_idx_t                eg_rd_page [`SW_NUM_PORTS];
    word_off_t                eg_rd_off [`SW_NUM_PORTS];
    bank_id_t                 eg_free_bank [`SW_NUM_PORTS];
    page_idx_t                eg_free_page [`SW_NUM_PORTS];
    half_t                    eg_bank_data [`SW_NUM_PORTS];
    page_idx_t                eg_bank_next [`SW_NUM_PORTS];

    // free-running owner of the bank read and free ports
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    for (genvar p = 0; p < `SW_NUM_PORTS; p++) begin : g_port
        // bank p follows whichever egress owns this cycle
        assign bk_rd_en[p]     = eg_rd_en[phase] && eg_rd_bank[phase] == bank_id_t'(p);
        assign bk_rd_page[p]   = eg_rd_page[phase];
        assign bk_rd_off[p]    = eg_rd_off[phase];
        assign bk_free_push[p] = eg_free_push[phase] && eg_free_bank[phase] == bank_id_t'(p);
        assign bk_free_page[p] = eg_free_page[phase];

        // egress bank register stays put while the read returns
        assign eg_bank_data[p] = bk_rd_data[eg_rd_bank[p]];
        assign eg_bank_next[p] = bk_rd_next[eg_rd_bank[p]];

        page_bank i_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .wr_en      (ig_wr_en[p]),
            .wr_page    (ig_wr_page[p]),
            .wr_off     (ig_wr_off[p]),
            .wr_data    (ig_wr_data[p]),
            .jt_wr_en   (ig_jt_wr_en[p]),
            .jt_wr_page (ig_jt_wr_page[p]),
            .jt_next    (ig_jt_next[p]),
            .rd_en      (bk_rd_en[p]),
            .rd_page    (bk_rd_page[p]),
            .rd_off     (bk_rd_off[p]),
            .rd_data    (bk_rd_data[p]),
            .rd_next    (bk_rd_next[p]),
            .page_pop   (ig_page_pop[p]),
            .free_push  (bk_free_push[p]),
            .free_page  (bk_free_page[p]),
            .free_head  (bk_free_head[p]),
            .free_count (bk_free_count[p])
        );

        port_ingress #(.BANK(bank_id_t'(p))) i_ingress (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr_sop      (wr_sop[p]),
            .wr_eop      (wr_eop[p]),
            .wr_vld      (wr_vld[p]),
            .wr_data     (wr_data[p]),
            .full        (full[p]),
            .free_head   (bk_free_head[p]),
            .free_count  (bk_free_count[p]),
            .page_pop    (ig_page_pop[p]),
            .wr_en       (ig_wr_en[p]),
            .wr_page     (ig_wr_page[p]),
            .wr_off      (ig_wr_off[p]),
            .wr_data_q   (ig_wr_data[p]),
            .jt_wr_en    (ig_jt_wr_en[p]),
            .jt_wr_page  (ig_jt_wr_page[p]),
            .jt_next     (ig_jt_next[p]),
            .desc_valid  (desc_valid[p]),
            .desc        (desc[p]),
            .desc_dest   (desc_dest[p]),
            .desc_accept (desc_accept[p])
        );

        port_egress #(.PORT(port_id_t'(p))) i_egress (
            .clk       (clk),
            .rst_n     (rst_n),
            .phase     (phase),
            .q_valid   (q_valid[p]),
            .q_desc    (q_desc[p]),
            .q_pop     (q_pop[p]),
            .rd_en     (eg_rd_en[p]),
            .rd_bank   (eg_rd_bank[p]),
            .rd_page   (eg_rd_page[p]),
            .rd_off    (eg_rd_off[p]),
            .bank_data (eg_bank_data[p]),
            .bank_next (eg_bank_next[p]),
            .free_push (eg_free_push[p]),
            .free_bank (eg_free_bank[p]),
            .free_page (eg_free_page[p]),
            .ready     (ready[p]),
            .rd_sop    (rd_sop[p]),
            .rd_eop    (rd_eop[p]),
            .rd_vld    (rd_vld[p]),
            .rd_data   (rd_data[p])
        );
    end

    desc_queue i_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .in_valid  (desc_valid),
        .in_desc   (desc),
        .in_dest   (desc_dest),
        .in_accept (desc_accept),
        .q_valid   (q_valid),
        .q_desc    (q_desc),
        .q_pop     (q_pop)
    );

endmodule

`default_nettype wire

//--- hdl/port_egress.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module port_egress #(
    parameter switch_pkg::port_id_t PORT = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  switch_pkg::port_id_t  phase,
    input  logic                  q_valid,
    input  switch_pkg::pkt_desc_t q_desc,
    output logic                  q_pop,
    output logic                  rd_en,
    output buffer_pkg::bank_id_t  rd_bank,
    output buffer_pkg::page_idx_t rd_page,
    output buffer_pkg::word_off_t rd_off,
    input  switch_pkg::half_t     bank_data,
    input  buffer_pkg::page_idx_t bank_next,
    output logic                  free_push,
    output buffer_pkg::bank_id_t  free_bank,
    output buffer_pkg::page_idx_t free_page,
    input  logic                  ready,
    output logic                  rd_sop,
    output logic                  rd_eop,
    output logic                  rd_vld,
    output switch_pkg::half_t     rd_data
);
    import buffer_pkg::*;
    import switch_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_READ, S_WAIT, S_PRESENT} state_t;

    state_t    state;
    bank_id_t  bank;
    page_idx_t page;
    word_off_t off;
    word_cnt_t remain;
    logic      first;
    logic      page_end;
    logic      issue;

    // reads only in owned cycles; a read may overlap the handshake
    assign issue = phase == PORT &&
                   (state == S_READ || (state == S_PRESENT && ready && remain != '0));

    assign q_pop   = state == S_IDLE && q_valid;
    assign rd_en   = issue;
    assign rd_bank = bank;
    assign rd_page = page;
    assign rd_off  = off;

    // page goes back to its list as its last halfword is read
    assign free_push = issue &&
                       (off == word_off_t'(`SW_PAGE_WORDS-1) || remain == word_cnt_t'(1));
    assign free_bank = bank;
    assign free_page = page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (q_valid) begin
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (issue) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    rd_vld <= 1'b1;
                    rd_sop <= first;
                    rd_eop <= remain == '0;
                    state  <= S_PRESENT;
                end
                default: begin
                    // output held until the sink takes it
                    if (ready) begin
                        rd_vld <= 1'b0;
                        rd_sop <= 1'b0;
                        rd_eop <= 1'b0;
                        if (issue) begin
                            state <= S_WAIT;
                        end else if (remain == '0) begin
                            state <= S_IDLE;
                        end else begin
                            state <= S_READ;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            bank   <= q_desc.head.bank;
            page   <= q_desc.head.page;
            off    <= '0;
            remain <= q_desc.count;
            first  <= 1'b1;
        end
        if (issue) begin
            off      <= off + 1'b1;
            remain   <= remain - 1'b1;
            page_end <= off == word_off_t'(`SW_PAGE_WORDS-1);
        end
        if (state == S_WAIT) begin
            rd_data <= bank_data;
            first   <= 1'b0;
            // follow the jump table into the next page
            if (page_end) begin
                page <= bank_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/desc_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module desc_queue (
    input  logic                     clk,
    input  logic                     rst_n,
    input  switch_pkg::port_id_t     phase,
    input  logic [`SW_NUM_PORTS-1:0] in_valid,
    input  switch_pkg::pkt_desc_t    in_desc [`SW_NUM_PORTS],
    input  switch_pkg::port_id_t     in_dest [`SW_NUM_PORTS],
    output logic [`SW_NUM_PORTS-1:0] in_accept,
    output logic [`SW_NUM_PORTS-1:0] q_valid,
    output switch_pkg::pkt_desc_t    q_desc [`SW_NUM_PORTS],
    input  logic [`SW_NUM_PORTS-1:0] q_pop
);
    import switch_pkg::*;

    localparam int PTR_W = $clog2(`SW_QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `SW_QUEUE_DEPTH;

    pkt_desc_t                fifo_mem [`SW_NUM_PORTS][`SW_QUEUE_DEPTH];
    logic [PTR_W-1:0]         rd_ptr [`SW_NUM_PORTS];
    logic [PTR_W-1:0]         wr_ptr [`SW_NUM_PORTS];
    logic [PTR_W:0]           fill [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0] fifo_full;
    logic [`SW_NUM_PORTS-1:0] push;
    pkt_desc_t                push_desc;

    // only the input named by phase may hand off, so no two writes collide
    always_comb begin
        push      = '0;
        in_accept = '0;
        push_desc = in_desc[phase];
        if (in_valid[phase] && !fifo_full[in_dest[phase]]) begin
            in_accept[phase]     = 1'b1;
            push[in_dest[phase]] = 1'b1;
        end
    end

    for (genvar d = 0; d < `SW_NUM_PORTS; d++) begin : g_dest
        assign fifo_full[d] = fill[d] == DEPTH;
        assign q_valid[d]   = fill[d] != '0;
        assign q_desc[d]    = fifo_mem[d][rd_ptr[d]];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rd_ptr[d] <= '0;
                wr_ptr[d] <= '0;
                fill[d]   <= '0;
            end else begin
                if (push[d]) begin
                    wr_ptr[d] <= wr_ptr[d] + 1'b1;
                end
                if (q_pop[d]) begin
                    rd_ptr[d] <= rd_ptr[d] + 1'b1;
                end
                if (push[d] && !q_pop[d]) begin
                    fill[d] <= fill[d] + 1'b1;
                end else if (q_pop[d] && !push[d]) begin
                    fill[d] <= fill[d] - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push[d]) begin
                fifo_mem[d][wr_ptr[d]] <= push_desc;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/port_ingress.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module port_ingress #(
    parameter buffer_pkg::bank_id_t BANK = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::half_t     wr_data,
    output logic                  full,
    input  buffer_pkg::page_idx_t free_head,
    input  buffer_pkg::free_cnt_t free_count,
    output logic                  page_pop,
    output logic                  wr_en,
    output buffer_pkg::page_idx_t wr_page,
    output buffer_pkg::word_off_t wr_off,
    output switch_pkg::half_t     wr_data_q,
    output logic                  jt_wr_en,
    output buffer_pkg::page_idx_t jt_wr_page,
    output buffer_pkg::page_idx_t jt_next,
    output logic                  desc_valid,
    output switch_pkg::pkt_desc_t desc,
    output switch_pkg::port_id_t  desc_dest,
    input  logic                  desc_accept
);
    import buffer_pkg::*;
    import switch_pkg::*;

    logic      in_pkt;
    logic      hw_take;
    logic      new_page;
    word_off_t off;
    word_off_t off_sel;
    word_cnt_t cnt;
    page_idx_t cur_page;
    page_idx_t next_page;
    page_idx_t page_sel;
    page_idx_t head_page;
    port_id_t  dest;

    // a halfword counts only inside a packet or when it opens one
    assign hw_take  = wr_vld && (wr_sop || in_pkt);
    assign new_page = wr_sop || off == '0;
    assign off_sel  = wr_sop ? '0 : off;
    assign page_sel = wr_sop ? free_head : (new_page ? next_page : cur_page);
    assign page_pop = hw_take && new_page;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            wr_en      <= 1'b0;
            jt_wr_en   <= 1'b0;
            desc_valid <= 1'b0;
            full       <= 1'b0;
        end else begin
            wr_en    <= hw_take;
            jt_wr_en <= hw_take && !wr_sop && off == '0;
            if (hw_take) begin
                in_pkt <= !wr_eop;
            end
            if (hw_take && wr_eop) begin
                desc_valid <= 1'b1;
            end else if (desc_accept) begin
                desc_valid <= 1'b0;
            end
            // the list count lags a pop by one cycle
            full <= (free_count - free_cnt_t'(page_pop)) < free_cnt_t'(`SW_MAX_PAGES);
        end
    end

    always_ff @(posedge clk) begin
        // list head one cycle behind for page changes
        next_page <= free_head;
        if (hw_take) begin
            wr_page    <= page_sel;
            wr_off     <= off_sel;
            wr_data_q  <= wr_data;
            cur_page   <= page_sel;
            off        <= off_sel + 1'b1;
            cnt        <= wr_sop ? word_cnt_t'(1) : cnt + 1'b1;
            jt_wr_page <= cur_page;
            jt_next    <= next_page;
        end
        // destination in bit 0 of the header
        if (hw_take && wr_sop) begin
            dest      <= port_id_t'(wr_data[0]);
            head_page <= free_head;
        end
        if (hw_take && wr_eop) begin
            desc.head  <= '{bank: BANK, page: head_page};
            desc.count <= cnt + 1'b1;
            desc_dest  <= dest;
        end
    end

endmodule

`default_nettype wire

//--- hdl/page_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module page_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  buffer_pkg::page_idx_t wr_page,
    input  buffer_pkg::word_off_t wr_off,
    input  switch_pkg::half_t     wr_data,
    input  logic                  jt_wr_en,
    input  buffer_pkg::page_idx_t jt_wr_page,
    input  buffer_pkg::page_idx_t jt_next,
    input  logic                  rd_en,
    input  buffer_pkg::page_idx_t rd_page,
    input  buffer_pkg::word_off_t rd_off,
    output switch_pkg::half_t     rd_data,
    output buffer_pkg::page_idx_t rd_next,
    input  logic                  page_pop,
    input  logic                  free_push,
    input  buffer_pkg::page_idx_t free_page,
    output buffer_pkg::page_idx_t free_head,
    output buffer_pkg::free_cnt_t free_count
);
    import buffer_pkg::*;
    import switch_pkg::*;

    half_t     data_mem [`SW_PAGES_PER_BANK*`SW_PAGE_WORDS];
    page_idx_t jump_mem [`SW_PAGES_PER_BANK];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[{wr_page, wr_off}] <= wr_data;
        end
        // previous page of a packet points at the one after it
        if (jt_wr_en) begin
            jump_mem[jt_wr_page] <= jt_next;
        end
    end

    // data and link come back together one cycle after the address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= data_mem[{rd_page, rd_off}];
            rd_next <= jump_mem[rd_page];
        end
    end

    free_page_list i_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop       (page_pop),
        .push      (free_push),
        .push_page (free_page),
        .head      (free_head),
        .count     (free_count)
    );

endmodule

`default_nettype wire

//--- hdl/free_page_list.sv
`timescale 1ns/10ps
`default_nettype none

`include "switch_macros.svh"

module free_page_list (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    input  logic                  push,
    input  buffer_pkg::page_idx_t push_page,
    output buffer_pkg::page_idx_t head,
    output buffer_pkg::free_cnt_t count
);
    import buffer_pkg::*;

    page_idx_t list_mem [`SW_PAGES_PER_BANK];
    page_idx_t rd_ptr;
    page_idx_t wr_ptr;

    assign head = list_mem[rd_ptr];

    // list starts full, so both pointers sit on slot 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= free_cnt_t'(`SW_PAGES_PER_BANK);
            for (int i = 0; i < `SW_PAGES_PER_BANK; i++) begin
                list_mem[i] <= page_idx_t'(i);
            end
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push) begin
                list_mem[wr_ptr] <= push_page;
                wr_ptr           <= wr_ptr + 1'b1;
            end
            // pop and push together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/switch_pkg.sv
`default_nettype none

`include "switch_macros.svh"

package switch_pkg;

    import buffer_pkg::*;

    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] port_id_t;

    typedef logic [`SW_DATA_W-1:0] half_t;

    // 1 to 64 halfwords
    typedef logic [$clog2(`SW_MAX_PAGES*`SW_PAGE_WORDS+1)-1:0] word_cnt_t;

    // handed from an ingress port to the queue of its destination
    typedef struct packed {
        buf_addr_t head;
        word_cnt_t count;
    } pkt_desc_t;

endpackage

`default_nettype wire

//--- hdl/buffer_pkg.sv
`default_nettype none

`include "switch_macros.svh"

package buffer_pkg;

    // one bank per input port
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0] bank_id_t;

    typedef logic [$clog2(`SW_PAGES_PER_BANK)-1:0] page_idx_t;

    // halfword position inside a page
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0] word_off_t;

    // bank in the upper bits, page below
    typedef struct packed {
        bank_id_t  bank;
        page_idx_t page;
    } buf_addr_t;

    // one bit wider than a page index so a full bank fits
    typedef logic [$clog2(`SW_PAGES_PER_BANK+1)-1:0] free_cnt_t;

endpackage

`default_nettype wire

//--- hdl/switch_macros.svh
`ifndef SWITCH_MACROS_SVH
`define SWITCH_MACROS_SVH

// input ports, output ports and banks come in equal numbers
`define SW_NUM_PORTS 2

// halfword width on both packet interfaces
`define SW_DATA_W 16

// bank geometry
`define SW_PAGE_WORDS 8
`define SW_PAGES_PER_BANK 32

// largest packet in pages (64 halfwords)
`define SW_MAX_PAGES 8

// descriptors held per destination
`define SW_QUEUE_DEPTH 8

`endif
